// File: common/burst_read_settings.svh
`ifndef BURST_READ_SETTINGS_SVH
`define BURST_READ_SETTINGS_SVH

// word address width, addresses count words and not bytes
`define BR_ADDR_WIDTH 20
`define BR_DATA_WIDTH 16

// zero based beat count, so 0 means one beat
`define BR_LEN_WIDTH 8

// address step between two beats of one burst
`define BR_STRIDE 2

// number of burst readers sharing the memory port
`define BR_READERS 2

// fifo depths are log2 of the slot count
`define BR_META_DEPTH_LOG2 3
`define BR_META_AF_BUF 2
`define BR_RES_DEPTH_LOG2 4
`define BR_RES_AF_BUF 8
`define BR_OWNER_DEPTH_LOG2 3
`define BR_OWNER_AF_BUF 2

`endif

// File: common/burst_read_pkg.sv
`default_nettype none

`include "burst_read_settings.svh"

package burst_read_pkg;

  // one memory word address
  typedef logic [`BR_ADDR_WIDTH-1:0] addr_t;

  // one memory word
  typedef logic [`BR_DATA_WIDTH-1:0] data_t;

  // zero based beat count of a burst request
  typedef logic [`BR_LEN_WIDTH-1:0] len_t;

  // burst reader control states
  // init_burst exists so the address iterator can settle after the load
  // before the first word request goes out
  typedef enum logic [1:0] {
    idle          = 2'b00,
    init_burst    = 2'b01,
    reading_beats = 2'b10,
    finish_burst  = 2'b11
  } reader_state_e;

endpackage

`default_nettype wire

// File: common/word_read_if.sv
`default_nettype none

// single word read channel between a requester and the memory side
interface word_read_if;
  import burst_read_pkg::*;

  // address half of the channel
  addr_t araddr;
  logic  arvalid;
  logic  arready;

  // return half of the channel, one word per address
  data_t rdata;
  logic  rvalid;
  logic  rready;

  // the side that issues word addresses and takes the data back
  modport manager(
    output araddr, arvalid, rready,
    input  arready, rdata, rvalid
  );

  // the side that accepts addresses and returns the data
  modport subordinate(
    input  araddr, arvalid, rready,
    output arready, rdata, rvalid
  );

endinterface

`default_nettype wire

// File: source/addr_iter.sv
`default_nettype none

module addr_iter #(
  parameter int INC_VAL = 1
) (
  input  logic                  axi_clk,
  input  logic                  init,
  input  burst_read_pkg::addr_t init_val,
  input  burst_read_pkg::addr_t max_val,
  input  logic                  inc,
  output burst_read_pkg::addr_t val,
  output logic                  last
);
  import burst_read_pkg::*;

  // the final address is captured at load time, so the caller only has to
  // hold max_val valid in the cycle where init is high
  addr_t max_q;

  always_ff @(posedge axi_clk) begin
    if (init) begin
      val   <= init_val;
      max_q <= max_val;
    end else if (inc) begin
      val <= val + addr_t'(INC_VAL);
    end
  end

  assign last = (val == max_q);

endmodule

`default_nettype wire

// File: source/sync_fifo.sv
`default_nettype none

module sync_fifo #(
  parameter int WIDTH           = 8,
  parameter int DEPTH_LOG2      = 3,
  parameter int ALMOST_FULL_BUF = 2
) (
  input  logic             axi_clk,
  input  logic             axi_resetn,
  input  logic             w_inc,
  input  logic [WIDTH-1:0] w_data,
  output logic             w_full,
  output logic             w_almost_full,
  input  logic             r_inc,
  output logic [WIDTH-1:0] r_data,
  output logic             r_empty
);
  localparam int DEPTH = 1 << DEPTH_LOG2;

  // pointers carry one extra wrap bit to tell full from empty
  typedef logic [DEPTH_LOG2:0] ptr_t;

  logic [WIDTH-1:0] ram[DEPTH];
  ptr_t             w_ptr;
  ptr_t             r_ptr;
  ptr_t             count;
  ptr_t             free_slots;
  logic             do_write;
  logic             do_read;

  // a push into a full fifo or a pop from an empty one is ignored
  assign do_write = w_inc && !w_full;
  assign do_read  = r_inc && !r_empty;

  assign count      = w_ptr - r_ptr;
  assign free_slots = ptr_t'(DEPTH) - count;

  assign r_empty       = (w_ptr == r_ptr);
  assign w_full        = (w_ptr[DEPTH_LOG2] != r_ptr[DEPTH_LOG2]) &&
                         (w_ptr[DEPTH_LOG2-1:0] == r_ptr[DEPTH_LOG2-1:0]);
  assign w_almost_full = (free_slots < ptr_t'(ALMOST_FULL_BUF));

  // head word is visible without a read cycle
  assign r_data = ram[r_ptr[DEPTH_LOG2-1:0]];

  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      w_ptr <= '0;
      r_ptr <= '0;
    end else begin
      if (do_write) begin
        w_ptr <= w_ptr + 1'b1;
      end
      if (do_read) begin
        r_ptr <= r_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge axi_clk) begin
    if (do_write) begin
      ram[w_ptr[DEPTH_LOG2-1:0]] <= w_data;
    end
  end

endmodule

`default_nettype wire

// File: burst_reader/burst_reader.sv
`default_nettype none

`include "burst_read_settings.svh"

module burst_reader (
  input  logic                  axi_clk,
  input  logic                  axi_resetn,
  input  burst_read_pkg::addr_t araddr,
  input  burst_read_pkg::len_t  arlen,
  input  logic                  arvalid,
  output logic                  arready,
  output burst_read_pkg::data_t rdata,
  output logic                  rlast,
  output logic                  rvalid,
  input  logic                  rready,
  word_read_if.manager          mem
);
  import burst_read_pkg::*;

  localparam addr_t STRIDE_A = addr_t'(`BR_STRIDE);

  reader_state_e state;
  reader_state_e next_state;

  // address iterator signals
  addr_t addr;
  addr_t addr_max;
  logic  addr_last;

  // set once the request for the final address has been issued
  logic  addr_done;

  logic  burst_start;
  logic  beat_read_start;
  logic  beat_read_accepted;
  logic  beat_read_done;
  logic  burst_done;

  // meta fifo holds the last flag of every outstanding word request
  logic  meta_af;
  logic  meta_last;

  // result fifo holds returned words with their last flag on top
  logic                    res_w_full;
  logic                    res_af;
  logic                    res_r_inc;
  logic                    res_r_empty;
  logic [`BR_DATA_WIDTH:0] res_w_data;
  logic [`BR_DATA_WIDTH:0] res_r_data;

  assign beat_read_accepted = mem.arvalid && mem.arready;
  assign beat_read_done     = mem.rvalid && mem.rready;
  assign burst_done         = rlast && rvalid && rready;

  always_comb begin
    next_state      = state;
    burst_start     = 1'b0;
    beat_read_start = 1'b0;

    case (state)
      idle: begin
        if (arvalid && arready) begin
          burst_start = 1'b1;
          next_state  = init_burst;
        end
      end

      // both fifos are empty here, so the first request needs no check
      init_burst: begin
        beat_read_start = 1'b1;
        next_state      = reading_beats;
      end

      // a new request may only replace one that is gone or leaving now
      reading_beats: begin
        if (!mem.arvalid || mem.arready) begin
          if (!addr_done) begin
            beat_read_start = !meta_af && !res_af;
          end else begin
            next_state = finish_burst;
          end
        end
      end

      finish_burst: begin
        if (burst_done) begin
          next_state = idle;
        end
      end

      default: begin
        next_state = idle;
      end
    endcase
  end

  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      state <= idle;
    end else begin
      state <= next_state;
    end
  end

  // ready for a new burst only when the machine sits in idle next cycle
  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      arready <= 1'b0;
    end else begin
      arready <= (next_state == idle);
    end
  end

  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      addr_done <= 1'b0;
    end else if (burst_start) begin
      addr_done <= 1'b0;
    end else if (beat_read_start) begin
      addr_done <= addr_last;
    end
  end

  // final address is start plus stride times the zero based count
  assign addr_max = araddr + (STRIDE_A * addr_t'(arlen));

  addr_iter #(
    .INC_VAL(`BR_STRIDE)
  ) iter (
    .axi_clk (axi_clk),
    .init    (burst_start),
    .init_val(araddr),
    .max_val (addr_max),
    .inc     (beat_read_start),
    .val     (addr),
    .last    (addr_last)
  );

  // word request register, held until the memory side takes it
  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      mem.arvalid <= 1'b0;
    end else if (beat_read_start) begin
      mem.arvalid <= 1'b1;
    end else if (beat_read_accepted) begin
      mem.arvalid <= 1'b0;
    end
  end

  always_ff @(posedge axi_clk) begin
    if (beat_read_start) begin
      mem.araddr <= addr;
    end
  end

  sync_fifo #(
    .WIDTH          (1),
    .DEPTH_LOG2     (`BR_META_DEPTH_LOG2),
    .ALMOST_FULL_BUF(`BR_META_AF_BUF)
  ) meta_fifo (
    .axi_clk      (axi_clk),
    .axi_resetn   (axi_resetn),
    .w_inc        (beat_read_start),
    .w_data       (addr_last),
    .w_full       (),
    .w_almost_full(meta_af),
    .r_inc        (beat_read_done),
    .r_data       (meta_last),
    .r_empty      ()
  );

  // returned words are taken as long as the result fifo has room
  assign mem.rready = !res_w_full;
  assign res_w_data = {meta_last, mem.rdata};

  sync_fifo #(
    .WIDTH          (`BR_DATA_WIDTH + 1),
    .DEPTH_LOG2     (`BR_RES_DEPTH_LOG2),
    .ALMOST_FULL_BUF(`BR_RES_AF_BUF)
  ) res_fifo (
    .axi_clk      (axi_clk),
    .axi_resetn   (axi_resetn),
    .w_inc        (beat_read_done),
    .w_data       (res_w_data),
    .w_full       (res_w_full),
    .w_almost_full(res_af),
    .r_inc        (res_r_inc),
    .r_data       (res_r_data),
    .r_empty      (res_r_empty)
  );

  assign res_r_inc      = rvalid && rready;
  assign {rlast, rdata} = res_r_data;

  // rvalid follows the fifo one cycle late and drops after each transfer,
  // which leaves a one cycle gap between beats
  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      rvalid <= 1'b0;
    end else if (rvalid && rready) begin
      rvalid <= 1'b0;
    end else if (!res_r_empty) begin
      rvalid <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: source/read_arbiter.sv
`default_nettype none

`include "burst_read_settings.svh"

module read_arbiter (
  input  logic             axi_clk,
  input  logic             axi_resetn,
  word_read_if.subordinate req0,
  word_read_if.subordinate req1,
  word_read_if.manager     mem
);
  localparam int OWNER_W = $clog2(`BR_READERS);

  // sel picks the requester shown on the shared address channel
  logic [OWNER_W-1:0] sel;
  logic [OWNER_W-1:0] pick;
  logic [OWNER_W-1:0] last_winner;
  logic [OWNER_W-1:0] locked_id;
  logic [OWNER_W-1:0] owner_head;
  logic               locked;
  logic               grant_en;
  logic               owner_af;
  logic               owner_empty;
  logic               addr_accepted;
  logic               data_returned;

  // with both requesting, the one that lost last time wins
  always_comb begin
    if (req0.arvalid && req1.arvalid) begin
      pick = ~last_winner;
    end else begin
      pick = req1.arvalid;
    end
  end

  // a shown request keeps its grant until the memory takes the address
  assign sel      = locked ? locked_id : pick;
  assign grant_en = locked || !owner_af;

  assign mem.araddr  = sel ? req1.araddr : req0.araddr;
  assign mem.arvalid = grant_en && (sel ? req1.arvalid : req0.arvalid);
  assign req0.arready = grant_en && !sel && mem.arready;
  assign req1.arready = grant_en && sel && mem.arready;

  assign addr_accepted = mem.arvalid && mem.arready;
  assign data_returned = mem.rvalid && mem.rready;

  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      locked      <= 1'b0;
      locked_id   <= '0;
      last_winner <= '0;
    end else if (addr_accepted) begin
      locked      <= 1'b0;
      last_winner <= sel;
    end else if (mem.arvalid) begin
      locked    <= 1'b1;
      locked_id <= sel;
    end
  end

  // owner queue keeps the requester of every accepted address in order
  sync_fifo #(
    .WIDTH          (OWNER_W),
    .DEPTH_LOG2     (`BR_OWNER_DEPTH_LOG2),
    .ALMOST_FULL_BUF(`BR_OWNER_AF_BUF)
  ) owner_fifo (
    .axi_clk      (axi_clk),
    .axi_resetn   (axi_resetn),
    .w_inc        (addr_accepted),
    .w_data       (sel),
    .w_full       (),
    .w_almost_full(owner_af),
    .r_inc        (data_returned),
    .r_data       (owner_head),
    .r_empty      (owner_empty)
  );

  // the memory returns in order, so the head of the queue owns the word
  assign req0.rdata  = mem.rdata;
  assign req1.rdata  = mem.rdata;
  assign req0.rvalid = mem.rvalid && !owner_empty && !owner_head;
  assign req1.rvalid = mem.rvalid && !owner_empty && owner_head;
  assign mem.rready  = !owner_empty && (owner_head ? req1.rready : req0.rready);

endmodule

`default_nettype wire

// File: source/burst_read_top.sv
`default_nettype none

module burst_read_top (
  input  logic                  axi_clk,
  input  logic                  axi_resetn,

  // burst port 0
  input  burst_read_pkg::addr_t rd0_araddr,
  input  burst_read_pkg::len_t  rd0_arlen,
  input  logic                  rd0_arvalid,
  output logic                  rd0_arready,
  output burst_read_pkg::data_t rd0_rdata,
  output logic                  rd0_rlast,
  output logic                  rd0_rvalid,
  input  logic                  rd0_rready,

  // burst port 1
  input  burst_read_pkg::addr_t rd1_araddr,
  input  burst_read_pkg::len_t  rd1_arlen,
  input  logic                  rd1_arvalid,
  output logic                  rd1_arready,
  output burst_read_pkg::data_t rd1_rdata,
  output logic                  rd1_rlast,
  output logic                  rd1_rvalid,
  input  logic                  rd1_rready,

  // shared single word memory port
  output burst_read_pkg::addr_t mem_araddr,
  output logic                  mem_arvalid,
  input  logic                  mem_arready,
  input  burst_read_pkg::data_t mem_rdata,
  input  logic                  mem_rvalid,
  output logic                  mem_rready
);

  word_read_if rd0_if ();
  word_read_if rd1_if ();
  word_read_if mem_if ();

  burst_reader reader0 (
    .axi_clk   (axi_clk),
    .axi_resetn(axi_resetn),
    .araddr    (rd0_araddr),
    .arlen     (rd0_arlen),
    .arvalid   (rd0_arvalid),
    .arready   (rd0_arready),
    .rdata     (rd0_rdata),
    .rlast     (rd0_rlast),
    .rvalid    (rd0_rvalid),
    .rready    (rd0_rready),
    .mem       (rd0_if.manager)
  );

  burst_reader reader1 (
    .axi_clk   (axi_clk),
    .axi_resetn(axi_resetn),
    .araddr    (rd1_araddr),
    .arlen     (rd1_arlen),
    .arvalid   (rd1_arvalid),
    .arready   (rd1_arready),
    .rdata     (rd1_rdata),
    .rlast     (rd1_rlast),
    .rvalid    (rd1_rvalid),
    .rready    (rd1_rready),
    .mem       (rd1_if.manager)
  );

  read_arbiter arbiter (
    .axi_clk   (axi_clk),
    .axi_resetn(axi_resetn),
    .req0      (rd0_if.subordinate),
    .req1      (rd1_if.subordinate),
    .mem       (mem_if.manager)
  );

  // the arbiter side of the shared channel goes straight to the pins
  assign mem_araddr     = mem_if.araddr;
  assign mem_arvalid    = mem_if.arvalid;
  assign mem_rready     = mem_if.rready;
  assign mem_if.arready = mem_arready;
  assign mem_if.rdata   = mem_rdata;
  assign mem_if.rvalid  = mem_rvalid;

endmodule

`default_nettype wire

// File: dv/word_mem_model.sv
`default_nettype none

// memory behind the shared word port, one word in flight at a time
module word_mem_model #(
  parameter logic [31:0] SEED = 32'hf80e_0772
) (
  input  logic                  axi_clk,
  input  logic                  axi_resetn,
  input  burst_read_pkg::addr_t araddr,
  input  logic                  arvalid,
  output logic                  arready,
  output burst_read_pkg::data_t rdata,
  output logic                  rvalid,
  input  logic                  rready
);
  import burst_read_pkg::*;

  integer      seed;
  logic        busy;
  addr_t       held_addr;
  int unsigned wait_cnt;
  logic        addr_taken = 1'b0;
  logic        word_taken = 1'b0;

  // handshakes are sampled at the rising edge, where the DUT sees them too
  // the address is captured here because the reader may replace it right after
  always @(posedge axi_clk) begin
    addr_taken = arvalid && arready;
    word_taken = rvalid && rready;
    if (addr_taken) begin
      held_addr = araddr;
    end
  end

  // outputs only move on the falling edge
  initial begin
    seed      = SEED;
    busy      = 1'b0;
    wait_cnt  = 0;
    arready   = 1'b0;
    rvalid    = 1'b0;
    rdata     = '0;
    forever begin
      @(negedge axi_clk);
      if (!axi_resetn) begin
        busy     = 1'b0;
        wait_cnt = 0;
        arready  = 1'b0;
        rvalid   = 1'b0;
      end else begin
        if (word_taken) begin
          rvalid = 1'b0;
          busy   = 1'b0;
        end
        // a remaining count of 0 shows the word at the very next rising edge
        if (addr_taken) begin
          busy     = 1'b1;
          wait_cnt = $unsigned($random(seed)) % 3;
        end else if (busy && wait_cnt != 0) begin
          wait_cnt = wait_cnt - 1;
        end
        if (busy && !rvalid && wait_cnt == 0) begin
          rvalid = 1'b1;
          rdata  = data_t'(held_addr) ^ 16'ha5c3;
        end
        // a new address is taken only while no word is held
        arready = !busy;
      end
    end
  end

endmodule

`default_nettype wire

// File: dv/burst_read_tb.sv
`default_nettype none

`include "burst_read_settings.svh"

module burst_read_tb;
  import burst_read_pkg::*;

  localparam int RAND_BURSTS     = 12;
  localparam int MAX_BEATS       = 16;
  // three directed bursts plus two random phases on two ports
  localparam int TOTAL_BURSTS    = 3 + 4 * RAND_BURSTS;
  localparam int WATCHDOG_CYCLES = TOTAL_BURSTS * MAX_BEATS * 40;

  logic  axi_clk = 1'b0;
  logic  axi_resetn;
  addr_t rd0_araddr;
  len_t  rd0_arlen;
  logic  rd0_arvalid;
  logic  rd0_arready;
  data_t rd0_rdata;
  logic  rd0_rlast;
  logic  rd0_rvalid;
  logic  rd0_rready;
  addr_t rd1_araddr;
  len_t  rd1_arlen;
  logic  rd1_arvalid;
  logic  rd1_arready;
  data_t rd1_rdata;
  logic  rd1_rlast;
  logic  rd1_rvalid;
  logic  rd1_rready;
  addr_t mem_araddr;
  logic  mem_arvalid;
  logic  mem_arready;
  data_t mem_rdata;
  logic  mem_rvalid;
  logic  mem_rready;

  // words still owed to each port, in the order they must come back
  data_t exp_data0[$];
  logic  exp_last0[$];
  data_t exp_data1[$];
  logic  exp_last1[$];

  int          error_count = 0;
  int          check_count = 0;
  logic        burst_open0 = 1'b0;
  logic        burst_open1 = 1'b0;
  logic        rready_random = 1'b0;
  integer      seed;
  integer      ready_seed;
  logic [31:0] ready_bits;
  addr_t       base0[RAND_BURSTS];
  len_t        len0[RAND_BURSTS];
  addr_t       base1[RAND_BURSTS];
  len_t        len1[RAND_BURSTS];

  always #5 axi_clk = ~axi_clk;

  burst_read_top UUT (
    .axi_clk    (axi_clk),
    .axi_resetn (axi_resetn),
    .rd0_araddr (rd0_araddr),
    .rd0_arlen  (rd0_arlen),
    .rd0_arvalid(rd0_arvalid),
    .rd0_arready(rd0_arready),
    .rd0_rdata  (rd0_rdata),
    .rd0_rlast  (rd0_rlast),
    .rd0_rvalid (rd0_rvalid),
    .rd0_rready (rd0_rready),
    .rd1_araddr (rd1_araddr),
    .rd1_arlen  (rd1_arlen),
    .rd1_arvalid(rd1_arvalid),
    .rd1_arready(rd1_arready),
    .rd1_rdata  (rd1_rdata),
    .rd1_rlast  (rd1_rlast),
    .rd1_rvalid (rd1_rvalid),
    .rd1_rready (rd1_rready),
    .mem_araddr (mem_araddr),
    .mem_arvalid(mem_arvalid),
    .mem_arready(mem_arready),
    .mem_rdata  (mem_rdata),
    .mem_rvalid (mem_rvalid),
    .mem_rready (mem_rready)
  );

  word_mem_model mem_model (
    .axi_clk   (axi_clk),
    .axi_resetn(axi_resetn),
    .araddr    (mem_araddr),
    .arvalid   (mem_arvalid),
    .arready   (mem_arready),
    .rdata     (mem_rdata),
    .rvalid    (mem_rvalid),
    .rready    (mem_rready)
  );

  // beat k of a burst reads base plus stride times k, and the memory
  // holds the low address bits xor a fixed pattern there
  function automatic data_t expected_word(input addr_t base, input int unsigned beat);
    addr_t a;
    a = base + addr_t'(`BR_STRIDE * beat);
    return data_t'(a) ^ 16'ha5c3;
  endfunction

  task automatic check_level(input string what, input logic got, input logic want);
    check_count++;
    assert (got === want) else begin
      error_count++;
      $display("CHECK FAILED at time %0t: %s is %b, expected %b", $time, what, got, want);
    end
  endtask

  task automatic check_return(input int port, input data_t data, input logic last);
    data_t exp_d;
    logic  exp_l;
    int    depth;
    depth = (port == 0) ? exp_data0.size() : exp_data1.size();
    assert (depth > 0) else begin
      error_count++;
      $display("port %0d returned a word at time %0t that no burst asked for", port, $time);
    end
    if (depth > 0) begin
      if (port == 0) begin
        exp_d = exp_data0.pop_front();
        exp_l = exp_last0.pop_front();
      end else begin
        exp_d = exp_data1.pop_front();
        exp_l = exp_last1.pop_front();
      end
      check_count++;
      assert (data === exp_d && last === exp_l) else begin
        error_count++;
        $display("CHECK FAILED at time %0t: port %0d got data %h last %b, expected %h last %b",
                 $time, port, data, last, exp_d, exp_l);
      end
    end
  endtask

  // the expected beats are queued first, then the request is held until taken
  task automatic send_burst(input int port, input addr_t base, input len_t len);
    int unsigned beats;
    int unsigned k;
    logic        taken;
    beats = 32'(len) + 1;
    @(negedge axi_clk);
    for (k = 0; k < beats; k++) begin
      if (port == 0) begin
        exp_data0.push_back(expected_word(base, k));
        exp_last0.push_back(k == beats - 1);
      end else begin
        exp_data1.push_back(expected_word(base, k));
        exp_last1.push_back(k == beats - 1);
      end
    end
    if (port == 0) begin
      rd0_araddr  = base;
      rd0_arlen   = len;
      rd0_arvalid = 1'b1;
    end else begin
      rd1_araddr  = base;
      rd1_arlen   = len;
      rd1_arvalid = 1'b1;
    end
    taken = 1'b0;
    while (!taken) begin
      @(posedge axi_clk);
      taken = (port == 0) ? rd0_arready : rd1_arready;
    end
    @(negedge axi_clk);
    if (port == 0) begin
      rd0_arvalid = 1'b0;
    end else begin
      rd1_arvalid = 1'b0;
    end
  endtask

  // bases and lengths of one random phase for both ports
  task automatic draw_bursts();
    int i;
    for (i = 0; i < RAND_BURSTS; i++) begin
      base0[i] = addr_t'($random(seed));
      len0[i]  = len_t'($unsigned($random(seed)) % MAX_BEATS);
      base1[i] = addr_t'($random(seed));
      len1[i]  = len_t'($unsigned($random(seed)) % MAX_BEATS);
    end
  endtask

  task automatic run_random_bursts(input int port);
    int i;
    for (i = 0; i < RAND_BURSTS; i++) begin
      if (port == 0) begin
        send_burst(0, base0[i], len0[i]);
      end else begin
        send_burst(1, base1[i], len1[i]);
      end
    end
  endtask

  // the queues only shrink at rising edges, so they are polled in between
  task automatic wait_drained();
    while (exp_data0.size() != 0 || exp_data1.size() != 0) begin
      @(negedge axi_clk);
    end
  endtask

  // every return transfer is compared, and arready must stay low while a burst is open
  initial begin
    forever begin
      @(posedge axi_clk);
      if (axi_resetn) begin
        assert (!(burst_open0 && rd0_arready)) else begin
          error_count++;
          $display("CHECK FAILED at time %0t: port 0 arready high during a burst", $time);
        end
        assert (!(burst_open1 && rd1_arready)) else begin
          error_count++;
          $display("CHECK FAILED at time %0t: port 1 arready high during a burst", $time);
        end
        if (rd0_arvalid && rd0_arready) begin
          burst_open0 = 1'b1;
        end
        if (rd1_arvalid && rd1_arready) begin
          burst_open1 = 1'b1;
        end
        if (rd0_rvalid && rd0_rready) begin
          check_return(0, rd0_rdata, rd0_rlast);
          if (rd0_rlast) begin
            burst_open0 = 1'b0;
          end
        end
        if (rd1_rvalid && rd1_rready) begin
          check_return(1, rd1_rdata, rd1_rlast);
          if (rd1_rlast) begin
            burst_open1 = 1'b0;
          end
        end
      end
    end
  end

  // rready is either held high or toggled at random on both ports
  initial begin
    ready_seed = 32'hf80e_0772;
    rd0_rready = 1'b1;
    rd1_rready = 1'b1;
    forever begin
      @(negedge axi_clk);
      if (rready_random) begin
        ready_bits = $random(ready_seed);
        rd0_rready = ready_bits[0];
        rd1_rready = ready_bits[1];
      end else begin
        rd0_rready = 1'b1;
        rd1_rready = 1'b1;
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge axi_clk);
    $display("watchdog expired after %0d cycles, the bursts did not complete", WATCHDOG_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    seed        = 32'hf80e_0772;
    axi_resetn  = 1'b0;
    rd0_araddr  = '0;
    rd0_arlen   = '0;
    rd0_arvalid = 1'b0;
    rd1_araddr  = '0;
    rd1_arlen   = '0;
    rd1_arvalid = 1'b0;
    repeat (10) @(negedge axi_clk);
    check_level("rd0_arready in reset", rd0_arready, 1'b0);
    check_level("rd1_arready in reset", rd1_arready, 1'b0);
    axi_resetn = 1'b1;

    // arready comes up one cycle after the reset is released
    @(posedge axi_clk);
    @(negedge axi_clk);
    check_level("rd0_rvalid after reset", rd0_rvalid, 1'b0);
    check_level("rd1_rvalid after reset", rd1_rvalid, 1'b0);
    check_level("mem_arvalid after reset", mem_arvalid, 1'b0);
    check_level("rd0_arready after reset", rd0_arready, 1'b1);
    check_level("rd1_arready after reset", rd1_arready, 1'b1);

    // eight beats on port 0
    send_burst(0, 20'h01230, 8'd7);
    wait_drained();

    // single beat bursts, the second one at the top of the address space
    send_burst(1, 20'h0abcd, 8'd0);
    send_burst(0, 20'hfffff, 8'd0);
    wait_drained();

    // both ports busy at once
    draw_bursts();
    fork
      run_random_bursts(0);
      run_random_bursts(1);
    join
    wait_drained();

    // same again with back pressure on the return side
    draw_bursts();
    @(posedge axi_clk);
    rready_random = 1'b1;
    fork
      run_random_bursts(0);
      run_random_bursts(1);
    join
    wait_drained();
    @(posedge axi_clk);
    rready_random = 1'b0;

    // nothing may trickle out once every expected word has arrived
    repeat (20) @(negedge axi_clk);
    check_level("rd0_rvalid when idle", rd0_rvalid, 1'b0);
    check_level("rd1_rvalid when idle", rd1_rvalid, 1'b0);
    check_level("rd0_arready when idle", rd0_arready, 1'b1);
    check_level("rd1_arready when idle", rd1_arready, 1'b1);

    $display("checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: burst_read.f
+incdir+common
common/burst_read_pkg.sv
common/word_read_if.sv
source/addr_iter.sv
source/sync_fifo.sv
burst_reader/burst_reader.sv
source/read_arbiter.sv
source/burst_read_top.sv
dv/word_mem_model.sv
dv/burst_read_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f burst_read.f \
  --top-module burst_read_tb \
  -o burst_read_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_output=$(./obj_dir/burst_read_sim)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_output" | grep -qx "Simulation finished: PASS"; then
  exit 0
fi
echo "pass message not found in the simulation output"
exit 1
